// File: source/chip_integrator.sv
`timescale 1ns/1ps

module chip_integrator (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_clear,
    input  logic                  i_enable,
    input  logic                  i_sample_valid,
    input  mrr_rx_pkg::sample_t   i_sample,
    output logic                  o_chip_valid,
    output mrr_rx_pkg::chip_t     o_chip_energy,
    output mrr_rx_pkg::chip_idx_t o_chip_idx
);
    import mrr_rx_pkg::*;

    logic [OVERSAMPLE_LOG2-1:0] sample_cnt;
    chip_idx_t                  chip_cnt;
    chip_t                      energy_acc;
    chip_t                      energy_next;
    logic                       take_sample;
    logic                       chip_done;

    assign take_sample = i_enable && i_sample_valid;
    assign chip_done   = take_sample && (sample_cnt == OVERSAMPLE_LOG2'(OVERSAMPLE - 1));
    assign energy_next = energy_acc + chip_t'(i_sample);

    // Sample position within the chip and the running chip number
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sample_cnt   <= '0;
            chip_cnt     <= '0;
            o_chip_valid <= 1'b0;
        end else begin
            o_chip_valid <= chip_done && !i_clear;
            if (i_clear) begin
                sample_cnt <= '0;
                chip_cnt   <= '0;
            end else if (chip_done) begin
                sample_cnt <= '0;
                // Lanes only look at the first chips, so the number just sticks at the top
                if (chip_cnt != '1) begin
                    chip_cnt <= chip_cnt + 1'b1;
                end
            end else if (take_sample) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            energy_acc <= '0;
        end else if (chip_done) begin
            energy_acc    <= '0;
            o_chip_energy <= energy_next;
            o_chip_idx    <= chip_cnt;
        end else if (take_sample) begin
            energy_acc <= energy_next;
        end
    end

endmodule

// File: source/loopback_sequencer.sv
`timescale 1ns/1ps

module loopback_sequencer (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_trigger,
    input  logic                 i_chip_valid,
    input  logic                 i_sync_valid,
    input  mrr_rx_pkg::offset_t  i_offset,
    input  mrr_tx_pkg::wait_t    i_wait_step,
    input  mrr_tx_pkg::tx_word_t i_tx_word,
    input  logic                 i_tx_disable,
    output logic                 o_clear,
    output logic                 o_enable,
    output logic                 o_busy,
    output logic                 o_tx_en,
    output logic                 o_tx_pulse
);
    import mrr_tx_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SYNC,
        ST_TURN,
        ST_TX
    } state_t;

    state_t                            state;
    logic [WAIT_WIDTH:0]               turn_target;
    logic [WAIT_WIDTH:0]               turn_cnt;
    logic [$clog2(SLOTS_PER_BIT)-1:0]  slot_cnt;
    logic [$clog2(TX_WORD_BITS)-1:0]   bit_cnt;
    logic                              slot_end;
    logic                              word_end;
    logic                              cur_bit;
    logic                              pulse_slot;

    // Turnaround covers the user wait plus the found preamble offset, both in chips
    assign turn_target = {1'b0, i_wait_step} + i_offset;

    assign slot_end = (slot_cnt == ($bits(slot_cnt))'(SLOTS_PER_BIT - 1));
    assign word_end = (bit_cnt == ($bits(bit_cnt))'(TX_WORD_BITS - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= ST_IDLE;
            turn_cnt <= '0;
            slot_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_trigger) begin
                        state <= ST_SYNC;
                    end
                end

                // Wait for the selector to report where the preamble sits
                ST_SYNC: begin
                    turn_cnt <= '0;
                    slot_cnt <= '0;
                    bit_cnt  <= '0;
                    if (i_sync_valid) begin
                        if (turn_target == '0) begin
                            state <= ST_TX;
                        end else begin
                            state <= ST_TURN;
                        end
                    end
                end

                ST_TURN: begin
                    if (i_chip_valid) begin
                        if (turn_cnt + 1'b1 == turn_target) begin
                            state <= ST_TX;
                        end else begin
                            turn_cnt <= turn_cnt + 1'b1;
                        end
                    end
                end

                // Every chip strobe closes one slot, four slots make one bit
                ST_TX: begin
                    if (i_chip_valid) begin
                        if (slot_end) begin
                            slot_cnt <= '0;
                            if (word_end) begin
                                state <= ST_IDLE;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            slot_cnt <= slot_cnt + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // A new trigger restarts the integrator and the lanes in the same cycle
    assign o_clear  = (state == ST_IDLE) && i_trigger;
    assign o_enable = (state != ST_IDLE);
    assign o_busy   = (state != ST_IDLE);
    assign o_tx_en  = (state == ST_TX);

    assign cur_bit = i_tx_word[bit_cnt];

    // A one bit pulses early in the bit, a zero bit in the middle
    assign pulse_slot = cur_bit ? (slot_cnt == ($bits(slot_cnt))'(ONE_SLOT)) :
                                  (slot_cnt == ($bits(slot_cnt))'(ZERO_SLOT));

    // Disabled transmit keeps the timing but leaves the modulator dark
    assign o_tx_pulse = o_tx_en && !i_tx_disable && pulse_slot;

endmodule

// File: source/mrr_loopback.sv
`timescale 1ns/1ps

module mrr_loopback (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_trigger,
    input  logic                 i_sample_valid,
    input  mrr_rx_pkg::sample_t  i_sample,
    input  mrr_tx_pkg::wait_t    i_wait_step,
    input  mrr_tx_pkg::tx_word_t i_tx_word,
    input  logic                 i_tx_disable,
    output logic                 o_busy,
    output logic                 o_sync_valid,
    output mrr_rx_pkg::offset_t  o_offset,
    output logic                 o_tx_en,
    output logic                 o_tx_pulse
);
    import mrr_rx_pkg::*;

    logic                   seq_clear;
    logic                   seq_enable;
    logic                   chip_valid;
    chip_t                  chip_energy;
    chip_idx_t              chip_idx;
    logic [NUM_OFFSETS-1:0] lane_done;
    corr_t                  lane_corr [NUM_OFFSETS];

    chip_integrator integrator_i (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_clear        (seq_clear),
        .i_enable       (seq_enable),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .o_chip_valid   (chip_valid),
        .o_chip_energy  (chip_energy),
        .o_chip_idx     (chip_idx)
    );

    // One correlator per candidate offset, all fed by the same chip stream
    for (genvar k = 0; k < NUM_OFFSETS; k++) begin : g_lane
        pn_offset_lane #(
            .LANE_OFFSET (k)
        ) lane_i (
            .i_clk         (clk),
            .i_rst         (rst),
            .i_clear       (seq_clear),
            .i_chip_valid  (chip_valid),
            .i_chip_energy (chip_energy),
            .i_chip_idx    (chip_idx),
            .o_done        (lane_done[k]),
            .o_corr        (lane_corr[k])
        );
    end

    offset_selector selector_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_done       (lane_done),
        .i_corr       (lane_corr),
        .o_sync_valid (o_sync_valid),
        .o_offset     (o_offset)
    );

    loopback_sequencer sequencer_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_trigger    (i_trigger),
        .i_chip_valid (chip_valid),
        .i_sync_valid (o_sync_valid),
        .i_offset     (o_offset),
        .i_wait_step  (i_wait_step),
        .i_tx_word    (i_tx_word),
        .i_tx_disable (i_tx_disable),
        .o_clear      (seq_clear),
        .o_enable     (seq_enable),
        .o_busy       (o_busy),
        .o_tx_en      (o_tx_en),
        .o_tx_pulse   (o_tx_pulse)
    );

endmodule

// File: source/mrr_rx_pkg.sv
package mrr_rx_pkg;

    // Energy samples arrive unsigned from the envelope detector
    localparam int SAMPLE_WIDTH = 16;

    // One chip is integrated over this many samples
    localparam int OVERSAMPLE      = 4;
    localparam int OVERSAMPLE_LOG2 = 2;

    // Four samples summed need two extra bits
    localparam int CHIP_WIDTH = SAMPLE_WIDTH + OVERSAMPLE_LOG2;

    // The chip number saturates at its all-ones value
    localparam int CHIP_IDX_WIDTH = 5;

    // Preamble pattern, the MSB is the first chip on air
    localparam int              PN_LEN = 15;
    localparam logic [PN_LEN-1:0] PN_SEQ = 15'b000100110101111;

    localparam int NUM_OFFSETS  = 4;
    localparam int OFFSET_WIDTH = 2;

    // Fifteen signed chip energies of 18 bits fit in 23 bits
    localparam int CORR_WIDTH = 23;

    typedef logic [SAMPLE_WIDTH-1:0]          sample_t;
    typedef logic [CHIP_WIDTH-1:0]            chip_t;
    typedef logic [CHIP_IDX_WIDTH-1:0]        chip_idx_t;
    typedef logic [OFFSET_WIDTH-1:0]          offset_t;
    typedef logic signed [CORR_WIDTH-1:0]     corr_t;

endpackage

// File: source/mrr_tx_pkg.sv
package mrr_tx_pkg;

    // Word sent back to the tag, LSB first
    localparam int TX_WORD_BITS = 32;

    // Pulse-position framing, each bit covers four chip slots
    localparam int SLOTS_PER_BIT = 4;
    localparam int ONE_SLOT      = 0;
    localparam int ZERO_SLOT     = 2;

    // Turnaround wait, counted in chips
    localparam int WAIT_WIDTH = 8;

    typedef logic [TX_WORD_BITS-1:0] tx_word_t;
    typedef logic [WAIT_WIDTH-1:0]   wait_t;

endpackage

// File: source/offset_selector.sv
`timescale 1ns/1ps

module offset_selector (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic [mrr_rx_pkg::NUM_OFFSETS-1:0] i_done,
    input  mrr_rx_pkg::corr_t                  i_corr [mrr_rx_pkg::NUM_OFFSETS],
    output logic                               o_sync_valid,
    output mrr_rx_pkg::offset_t                o_offset
);
    import mrr_rx_pkg::*;

    corr_t   corr_q   [NUM_OFFSETS];
    corr_t   corr_cur [NUM_OFFSETS];
    corr_t   best_corr;
    offset_t best_offset;

    // Lanes finish one chip apart, so hold each result until the last one arrives
    always_ff @(posedge i_clk) begin
        for (int k = 0; k < NUM_OFFSETS; k++) begin
            if (i_done[k]) begin
                corr_q[k] <= i_corr[k];
            end
        end
    end

    // The lane finishing right now is taken straight from its port
    always_comb begin
        for (int k = 0; k < NUM_OFFSETS; k++) begin
            corr_cur[k] = i_done[k] ? i_corr[k] : corr_q[k];
        end
    end

    // Start from zero so only a positive match can win; strict compare keeps the lower lane
    always_comb begin
        best_corr   = '0;
        best_offset = '0;
        for (int k = 0; k < NUM_OFFSETS; k++) begin
            if (corr_cur[k] > best_corr) begin
                best_corr   = corr_cur[k];
                best_offset = offset_t'(k);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_sync_valid <= 1'b0;
            o_offset     <= '0;
        end else begin
            o_sync_valid <= i_done[NUM_OFFSETS-1];
            if (i_done[NUM_OFFSETS-1]) begin
                o_offset <= best_offset;
            end
        end
    end

endmodule

// File: source/pn_offset_lane.sv
`timescale 1ns/1ps

module pn_offset_lane #(
    parameter int LANE_OFFSET = 0
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_clear,
    input  logic                  i_chip_valid,
    input  mrr_rx_pkg::chip_t     i_chip_energy,
    input  mrr_rx_pkg::chip_idx_t i_chip_idx,
    output logic                  o_done,
    output mrr_rx_pkg::corr_t     o_corr
);
    import mrr_rx_pkg::*;

    chip_idx_t         chip_pos;
    logic [PN_LEN-1:0] pn_shifted;
    logic              in_window;
    logic              last_chip;
    logic              pn_one;
    corr_t             energy_ext;
    corr_t             corr_acc;

    // Position of the incoming chip relative to where this lane expects the preamble
    assign chip_pos  = i_chip_idx - chip_idx_t'(LANE_OFFSET);
    assign in_window = (i_chip_idx >= chip_idx_t'(LANE_OFFSET)) &&
                       (chip_pos < chip_idx_t'(PN_LEN));
    assign last_chip = in_window && (chip_pos == chip_idx_t'(PN_LEN - 1));

    // PN bit for this chip, walking the pattern from the MSB
    assign pn_shifted = PN_SEQ << chip_pos;
    assign pn_one     = pn_shifted[PN_LEN-1];

    assign energy_ext = {{(CORR_WIDTH - CHIP_WIDTH){1'b0}}, i_chip_energy};

    // A one chip is expected dark, so its energy counts against the match
    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            corr_acc <= '0;
        end else if (i_chip_valid && in_window) begin
            if (pn_one) begin
                corr_acc <= corr_acc - energy_ext;
            end else begin
                corr_acc <= corr_acc + energy_ext;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_done <= 1'b0;
        end else begin
            o_done <= i_chip_valid && last_chip && !i_clear;
        end
    end

    assign o_corr = corr_acc;

endmodule

// File: verification/mrr_loopback_tb.sv
`timescale 1ns/1ps

module mrr_loopback_tb;
    import mrr_rx_pkg::*;
    import mrr_tx_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int MAX_GAP   = 4;
    localparam int CLK_NS    = 20;
    localparam int TX_SLOTS  = TX_WORD_BITS * SLOTS_PER_BIT;

    // Every test may need the preamble, the widest turnaround and a full transmit
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * (18 + 255 + 3 + TX_SLOTS) *
                                     OVERSAMPLE * MAX_GAP * CLK_NS + 40000;

    logic        clk;
    logic        rst;
    logic        i_trigger;
    logic        i_sample_valid;
    sample_t     i_sample;
    wait_t       i_wait_step;
    tx_word_t    i_tx_word;
    logic        i_tx_disable;
    logic        o_busy;
    logic        o_sync_valid;
    offset_t     o_offset;
    logic        o_tx_en;
    logic        o_tx_pulse;

    logic        chip_close;
    logic        chip_tick;
    logic        tx_en_q;
    logic        triggered;
    int          exp_offset;
    int          exp_wait;
    tx_word_t    exp_word;
    logic        exp_disable;
    int          sync_count;
    int          turn_chips;
    int          tx_slots;
    int          mismatches;
    int          failures;
    logic [31:0] lfsr_state;

    mrr_loopback dut_i (
        .clk            (clk),
        .rst            (rst),
        .i_trigger      (i_trigger),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .i_wait_step    (i_wait_step),
        .i_tx_word      (i_tx_word),
        .i_tx_disable   (i_tx_disable),
        .o_busy         (o_busy),
        .o_sync_valid   (o_sync_valid),
        .o_offset       (o_offset),
        .o_tx_en        (o_tx_en),
        .o_tx_pulse     (o_tx_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input longint expected,
                                   input longint actual);
        mismatches++;
        $display("mismatch at %0t ns: %s expected %0d, actual %0d", $time, name, expected,
                 actual);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Zero chips of the preamble come back bright, one chips stay dark
    function automatic sample_t chip_sample(input int chip, input int offset,
                                            input logic zero_run);
        int pn_pos;
        pn_pos = chip - offset;
        if (zero_run) begin
            return '0;
        end
        if (pn_pos < 0 || pn_pos >= PN_LEN) begin
            return sample_t'(take_bits(12));
        end
        if (PN_SEQ[PN_LEN - 1 - pn_pos]) begin
            return 16'h0100 + sample_t'(take_bits(6));
        end
        return 16'h4000 + sample_t'(take_bits(6));
    endfunction

    function automatic logic expected_pulse(input tx_word_t word, input int slot,
                                            input logic disable_tx);
        logic bit_val;
        int   pos;
        bit_val = word[slot / SLOTS_PER_BIT];
        pos     = slot % SLOTS_PER_BIT;
        if (disable_tx) begin
            return 1'b0;
        end
        return bit_val ? (pos == ONE_SLOT) : (pos == ZERO_SLOT);
    endfunction

    task automatic send_sample(input sample_t value, input logic closes_chip,
                               input logic retrig);
        int gap;
        gap = int'(take_bits(2));
        repeat (gap) begin
            @(posedge clk);
            i_sample_valid <= 1'b0;
            i_trigger      <= 1'b0;
            chip_close     <= 1'b0;
        end
        @(posedge clk);
        i_sample_valid <= 1'b1;
        i_sample       <= value;
        i_trigger      <= retrig;
        chip_close     <= closes_chip;
    endtask

    task automatic send_chip(input int chip, input int offset, input logic zero_run,
                             input logic retrig);
        sample_t value;
        for (int s = 0; s < OVERSAMPLE; s++) begin
            value = chip_sample(chip, offset, zero_run);
            send_sample(value, s == OVERSAMPLE - 1, retrig && (s == 0));
        end
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        i_sample_valid <= 1'b0;
        i_trigger      <= 1'b0;
        chip_close     <= 1'b0;
        repeat (5) @(posedge clk);
    endtask

    // Chip 0 starts with the first sample after the trigger cycle
    task automatic run_test(input int offset, input wait_t wait_step, input tx_word_t word,
                            input logic disable_tx, input logic zero_run, input logic retrig);
        int chip;
        @(posedge clk);
        i_trigger      <= 1'b1;
        i_sample_valid <= 1'b0;
        chip_close     <= 1'b0;
        i_wait_step    <= wait_step;
        i_tx_word      <= word;
        i_tx_disable   <= disable_tx;
        triggered      <= 1'b1;
        exp_offset     <= offset;
        exp_wait       <= int'(wait_step);
        exp_word       <= word;
        exp_disable    <= disable_tx;
        for (int c = 0; c < 18; c++) begin
            send_chip(c, offset, zero_run, 1'b0);
        end
        chip = 18;
        // The second trigger lands after the sync, while the transmit is running
        while (o_busy) begin
            send_chip(chip, offset, zero_run, retrig && (chip == 20));
            chip++;
        end
        idle_inputs();
        assert (sync_count == 1)
            else report_mismatch("o_sync_valid count", 1, sync_count);
    endtask

    // A chip tick lines up with the integrator's chip strobe, one cycle after the boundary
    always @(posedge clk) begin
        if (rst) begin
            chip_tick  <= 1'b0;
            tx_en_q    <= 1'b0;
            sync_count <= 0;
            turn_chips <= 0;
            tx_slots   <= 0;
        end else begin
            chip_tick <= chip_close && i_sample_valid;
            tx_en_q   <= o_tx_en;
            if (i_trigger && !o_busy) begin
                sync_count <= 0;
            end
            if (o_sync_valid) begin
                sync_count <= sync_count + 1;
                turn_chips <= 0;
                tx_slots   <= 0;
                assert (int'(o_offset) == exp_offset)
                    else report_mismatch("o_offset", exp_offset, o_offset);
            end else if (chip_tick && !o_tx_en) begin
                turn_chips <= turn_chips + 1;
            end
            if (o_tx_en && !tx_en_q) begin
                assert (turn_chips == exp_wait + exp_offset)
                    else report_mismatch("turnaround chips", exp_wait + exp_offset, turn_chips);
            end
            if (o_tx_en && chip_tick) begin
                if (tx_slots >= TX_SLOTS) begin
                    report_failure("transmit ran past the last slot of the word");
                end else begin
                    assert (o_tx_pulse == expected_pulse(exp_word, tx_slots, exp_disable))
                        else report_mismatch("o_tx_pulse",
                                             expected_pulse(exp_word, tx_slots, exp_disable),
                                             o_tx_pulse);
                end
                tx_slots <= tx_slots + 1;
            end
            if (!o_tx_en && tx_en_q) begin
                assert (tx_slots == TX_SLOTS)
                    else report_mismatch("o_tx_en chips", TX_SLOTS, tx_slots);
            end
        end
    end

    idle_before_trigger: assert property (@(posedge clk) disable iff (rst)
        !triggered |-> !(o_busy || o_sync_valid || o_tx_en || o_tx_pulse))
        else report_failure("DUT left idle before the first trigger");

    busy_after_trigger: assert property (@(posedge clk) disable iff (rst)
        (i_trigger && !o_busy) |=> o_busy)
        else report_failure("o_busy did not rise after an accepted trigger");

    busy_ends_with_tx: assert property (@(posedge clk) disable iff (rst)
        $fell(o_busy) == $fell(o_tx_en))
        else report_failure("o_busy and o_tx_en did not fall in the same cycle");

    pulse_inside_tx: assert property (@(posedge clk) disable iff (rst)
        o_tx_pulse |-> o_tx_en)
        else report_failure("o_tx_pulse high outside of transmit");

    dark_when_disabled: assert property (@(posedge clk) disable iff (rst)
        exp_disable |-> !o_tx_pulse)
        else report_mismatch("o_tx_pulse", 0, 1);

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before all tests finished");
        $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int       offset;
        wait_t    wait_step;
        tx_word_t word;
        lfsr_state     = 32'h461634d6;
        mismatches     = 0;
        failures       = 0;
        triggered      = 1'b0;
        exp_offset     = 0;
        exp_wait       = 0;
        exp_word       = '0;
        exp_disable    = 1'b0;
        chip_close     = 1'b0;
        rst            = 1'b1;
        i_trigger      = 1'b0;
        i_sample_valid = 1'b0;
        i_sample       = '0;
        i_wait_step    = '0;
        i_tx_word      = '0;
        i_tx_disable   = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // Outputs must stay quiet until the first trigger
        repeat (20) @(posedge clk);

        for (int t = 0; t < NUM_TESTS - 1; t++) begin
            offset    = int'(take_bits(2));
            wait_step = wait_t'(take_bits(8));
            word      = take_bits(32);
            run_test(offset, wait_step, word, t == NUM_TESTS - 2, 1'b0, 1'b0);
        end

        // Silent channel with no turnaround, plus a trigger while busy
        word = take_bits(32);
        run_test(0, '0, word, 1'b0, 1'b1, 1'b1);

        $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
source/mrr_rx_pkg.sv
source/mrr_tx_pkg.sv
source/chip_integrator.sv
source/pn_offset_lane.sv
source/offset_selector.sv
source/loopback_sequencer.sv
source/mrr_loopback.sv
verification/mrr_loopback_tb.sv
